/* hdl/core_ctrl_pkg.sv */
// Shared control types and IDs; only machine-mode irqs 31..16, 11, 7, 3 are known to the design
package core_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////////////////////////////////////////

  // Top-level control state of the core
  // RESET is left on the first edge after reset is released
  // BOOT_WAIT holds the core until fetch enable is seen
  // RUN is normal execution, irqs are taken here
  // SLEEP is entered by WFI, left by wake-up or debug
  // DEBUG_HALT is left only through dret
  typedef enum logic [2:0] {
    RESET      = 3'd0,
    BOOT_WAIT  = 3'd1,
    RUN        = 3'd2,
    SLEEP      = 3'd3,
    DEBUG_HALT = 3'd4
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt encoding
  ////////////////////////////////////////////////////////////////////////////

  // Width of an interrupt ID
  // 5 bits cover all 32 irq lines
  parameter int unsigned IRQ_ID_W = 5;

  // Standard machine interrupts, bit positions in irq_i / mie
  // Machine external interrupt
  parameter int unsigned IRQ_MEI = 11;
  // Machine software interrupt
  parameter int unsigned IRQ_MSI = 3;
  // Machine timer interrupt
  parameter int unsigned IRQ_MTI = 7;

  // First of the platform fast interrupts
  // Fast lines run from here up to bit 31
  parameter int unsigned IRQ_FAST_LO = 16;

  // Priority among these, highest first
  //   fast 31 down to fast 16
  //   MEI, then MSI, then MTI
  // All remaining bit positions are reserved and never pend

endpackage

/* hdl/int_controller.sv */
// Pending vector is a registered level, not cleared on ack; mie and global enable are inputs
module int_controller (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // Interrupt lines and masks from outside
  input  logic [31:0]                          irq_i,
  input  logic [31:0]                          mie_i,
  input  logic                                 m_irq_enable_i,

  // To the controller FSM
  output logic                                 irq_req_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0]   irq_id_o,
  output logic                                 irq_wu_o
);

  // Lines that may ever pend
  // Fast range plus the three standard machine irqs
  localparam logic [31:0] IRQ_SUPPORTED =
    (32'hFFFF_FFFF << core_ctrl_pkg::IRQ_FAST_LO) |
    (32'd1 << core_ctrl_pkg::IRQ_MEI) |
    (32'd1 << core_ctrl_pkg::IRQ_MSI) |
    (32'd1 << core_ctrl_pkg::IRQ_MTI);

  // Masked pending lines, sampled every cycle
  logic [31:0]                        pend_q;
  // Global enable, sampled with the pending vector
  logic                               irq_en_q;
  // Winner of the priority search
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id;

  ////////////////////////////////////////////////////////////////////////////
  // Pending register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q   <= '0;
      irq_en_q <= 1'b0;
    end else begin
      // Unsupported lines are dropped here
      pend_q   <= irq_i & mie_i & IRQ_SUPPORTED;
      irq_en_q <= m_irq_enable_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority search
  ////////////////////////////////////////////////////////////////////////////

  // Lowest priority first, later hits overwrite
  always_comb begin : prio_sel
    irq_id = '0;
    // Standard irqs, MTI lowest then MSI then MEI
    if (pend_q[core_ctrl_pkg::IRQ_MTI]) begin
      irq_id = core_ctrl_pkg::IRQ_ID_W'(core_ctrl_pkg::IRQ_MTI);
    end
    if (pend_q[core_ctrl_pkg::IRQ_MSI]) begin
      irq_id = core_ctrl_pkg::IRQ_ID_W'(core_ctrl_pkg::IRQ_MSI);
    end
    if (pend_q[core_ctrl_pkg::IRQ_MEI]) begin
      irq_id = core_ctrl_pkg::IRQ_ID_W'(core_ctrl_pkg::IRQ_MEI);
    end
    // Fast irqs beat all standard ones
    // Ascending scan so the highest index ends up winning
    for (int i = core_ctrl_pkg::IRQ_FAST_LO; i < 32; i++) begin
      if (pend_q[i]) begin
        irq_id = core_ctrl_pkg::IRQ_ID_W'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Take only with global enable set
  assign irq_req_o = (|pend_q) & irq_en_q;
  assign irq_id_o  = irq_id;

  // Wake-up ignores the global enable, as WFI requires
  assign irq_wu_o  = |pend_q;

endmodule

/* hdl/debug_req_unit.sv */
// debug_req_i may be fully asynchronous; DBG_SYNC_STAGES must be 2 or more, pend is sticky until ack
module debug_req_unit #(
  parameter int unsigned DBG_SYNC_STAGES = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Raw request from the debug module
  input  logic debug_req_i,

  // Entry to debug mode, from the FSM
  input  logic dbg_ack_i,

  // Held request, to the FSM
  output logic dbg_pend_o
);

  // Synchronizer flops, bit 0 samples the pin
  logic [DBG_SYNC_STAGES-1:0] sync_q;
  // Synchronized request level
  logic                       req_sync;
  // Sticky pending flag
  logic                       pend_q;

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      // Shift toward the MSB
      sync_q <= {sync_q[DBG_SYNC_STAGES-2:0], debug_req_i};
    end
  end

  assign req_sync = sync_q[DBG_SYNC_STAGES-1];

  ////////////////////////////////////////////////////////////////////////////
  // Pending flag
  ////////////////////////////////////////////////////////////////////////////

  // Set by the synced level
  // A short pulse is kept until the FSM takes it,
  // even if the core sleeps or is busy meanwhile
  // Ack clears it, but a request still high wins over the ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else if (req_sync) begin
      pend_q <= 1'b1;
    end else if (dbg_ack_i) begin
      pend_q <= 1'b0;
    end
  end

  assign dbg_pend_o = pend_q;

endmodule

/* hdl/core_ctrl_fsm.sv */
// No pipeline behind this FSM; wfi_i and dret_i are one-cycle strobes, irqs pend as levels
module core_ctrl_fsm (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // Core control strobes and levels
  input  logic                                 fetch_enable_i,
  input  logic                                 wfi_i,
  input  logic                                 dret_i,

  // From the interrupt controller
  input  logic                                 irq_req_i,
  input  logic [core_ctrl_pkg::IRQ_ID_W-1:0]   irq_id_i,
  input  logic                                 irq_wu_i,

  // From the debug request unit
  input  logic                                 dbg_pend_i,

  // Acknowledge pulses
  output logic                                 irq_ack_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0]   irq_id_o,
  output logic                                 dbg_ack_o,

  // Status
  output logic                                 core_sleep_o,
  output logic                                 debug_halted_o,
  output logic                                 debug_running_o,
  output logic                                 debug_havereset_o
);

  core_ctrl_pkg::ctrl_state_e         state_q;
  core_ctrl_pkg::ctrl_state_e         state_d;

  // Registered ack pulses and taken ID
  logic                               irq_ack_q;
  logic                               irq_ack_d;
  logic                               dbg_ack_q;
  logic                               dbg_ack_d;
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_q;

  // High from reset until debug mode is first entered
  logic                               havereset_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : next_state
    state_d   = state_q;
    irq_ack_d = 1'b0;
    dbg_ack_d = 1'b0;

    case (state_q)
      core_ctrl_pkg::RESET: begin
        state_d = core_ctrl_pkg::BOOT_WAIT;
      end

      core_ctrl_pkg::BOOT_WAIT: begin
        // Wait for the system to let the core go
        if (fetch_enable_i) begin
          state_d = core_ctrl_pkg::RUN;
        end
      end

      core_ctrl_pkg::RUN: begin
        if (dbg_pend_i) begin
          // Debug beats interrupts
          state_d   = core_ctrl_pkg::DEBUG_HALT;
          dbg_ack_d = 1'b1;
        end else if (irq_req_i && !irq_ack_q) begin
          // Take the irq, one idle cycle after each ack
          // so that a held line still gives separate pulses
          irq_ack_d = 1'b1;
        end else if (wfi_i && !irq_wu_i) begin
          // WFI with nothing pending
          state_d = core_ctrl_pkg::SLEEP;
        end
      end

      core_ctrl_pkg::SLEEP: begin
        if (dbg_pend_i) begin
          state_d   = core_ctrl_pkg::DEBUG_HALT;
          dbg_ack_d = 1'b1;
        end else if (irq_wu_i) begin
          // Any masked irq wakes, global enable or not
          state_d = core_ctrl_pkg::RUN;
        end
      end

      core_ctrl_pkg::DEBUG_HALT: begin
        if (dret_i) begin
          state_d = core_ctrl_pkg::RUN;
        end
      end

      default: begin
        // Unused encodings, restart cleanly
        state_d = core_ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // State and pulse registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= core_ctrl_pkg::RESET;
      irq_ack_q   <= 1'b0;
      dbg_ack_q   <= 1'b0;
      irq_id_q    <= '0;
      havereset_q <= 1'b1;
    end else begin
      state_q   <= state_d;
      irq_ack_q <= irq_ack_d;
      dbg_ack_q <= dbg_ack_d;
      // ID is held until the next ack
      if (irq_ack_d) begin
        irq_id_q <= irq_id_i;
      end
      // Every entry to DEBUG_HALT comes with a dbg ack
      if (dbg_ack_d) begin
        havereset_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign irq_ack_o         = irq_ack_q;
  assign irq_id_o          = irq_id_q;
  assign dbg_ack_o         = dbg_ack_q;

  // Status decoded from the state register
  assign core_sleep_o      = (state_q == core_ctrl_pkg::SLEEP);
  assign debug_halted_o    = (state_q == core_ctrl_pkg::DEBUG_HALT);
  // Sleeping still counts as running for the debugger
  assign debug_running_o   = (state_q == core_ctrl_pkg::RUN) ||
                             (state_q == core_ctrl_pkg::SLEEP);
  assign debug_havereset_o = havereset_q;

endmodule

/* hdl/core_ctrl_top.sv */
// Control corner only, no pipeline or CSRs; DBG_SYNC_STAGES must be at least 2
module core_ctrl_top #(
  parameter int unsigned DBG_SYNC_STAGES = 2
) (
  // Clock and reset
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // Interrupt inputs, mask and global enable
  input  logic [31:0]                          irq_i,
  input  logic [31:0]                          mie_i,
  input  logic                                 m_irq_enable_i,

  // Debug request
  input  logic                                 debug_req_i,

  // Core control
  input  logic                                 fetch_enable_i,
  input  logic                                 wfi_i,
  input  logic                                 dret_i,

  // Acks
  output logic                                 irq_ack_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0]   irq_id_o,
  output logic                                 dbg_ack_o,

  // Status
  output logic                                 core_sleep_o,
  output logic                                 debug_halted_o,
  output logic                                 debug_running_o,
  output logic                                 debug_havereset_o
);

  // Interrupt controller results
  logic                               irq_req;
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id;
  logic                               irq_wu;
  // Held debug request
  logic                               dbg_pend;

  ////////////////////////////////////////////////////////////////////////////
  // Front-ends
  ////////////////////////////////////////////////////////////////////////////

  int_controller u_int_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .irq_i          ( irq_i          ),
    .mie_i          ( mie_i          ),
    .m_irq_enable_i ( m_irq_enable_i ),
    .irq_req_o      ( irq_req        ),
    .irq_id_o       ( irq_id         ),
    .irq_wu_o       ( irq_wu         )
  );

  debug_req_unit #(
    .DBG_SYNC_STAGES ( DBG_SYNC_STAGES )
  ) u_dbg_req (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .debug_req_i ( debug_req_i ),
    // Ack goes out and back to clear the flag
    .dbg_ack_i   ( dbg_ack_o   ),
    .dbg_pend_o  ( dbg_pend    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////////////////////

  core_ctrl_fsm u_ctrl_fsm (
    .clk_i             ( clk_i             ),
    .rst_n_i           ( rst_n_i           ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .wfi_i             ( wfi_i             ),
    .dret_i            ( dret_i            ),
    .irq_req_i         ( irq_req           ),
    .irq_id_i          ( irq_id            ),
    .irq_wu_i          ( irq_wu            ),
    .dbg_pend_i        ( dbg_pend          ),
    .irq_ack_o         ( irq_ack_o         ),
    .irq_id_o          ( irq_id_o          ),
    .dbg_ack_o         ( dbg_ack_o         ),
    .core_sleep_o      ( core_sleep_o      ),
    .debug_halted_o    ( debug_halted_o    ),
    .debug_running_o   ( debug_running_o   ),
    .debug_havereset_o ( debug_havereset_o )
  );

endmodule

/* tests/core_ctrl_stim.svh */
// Stimulus tasks for tb_core_ctrl; fetch enable stays set once reset_and_boot has run
`ifndef CORE_CTRL_STIM_SVH
`define CORE_CTRL_STIM_SVH

  // Drop all lines and let the pending register drain
  task automatic clear_irqs();
    irq_i = '0;
    repeat (3) tick();
  endtask

  task automatic expect_no_ack(input int cycles);
    no_ack_exp = 1'b1;
    repeat (cycles) tick();
    no_ack_exp = 1'b0;
  endtask

  // One mask and line vector, ID expected by the priority rule
  task automatic take_irq(input logic [31:0] mask, input logic [31:0] lines);
    logic [31:0] masked;
    clear_irqs();
    mie_i = mask;
    irq_i = lines;
    masked = lines & mask & IRQ_LINES;
    exp_id = prio_id(masked);
    if (masked != '0) begin
      wait_for(SEL_ACK, 1'b1, 6, "irq_ack_o for a pending interrupt");
    end
  endtask

  task automatic enter_sleep();
    wfi_i = 1'b1;
    tick();
    wfi_i = 1'b0;
    wait_for(SEL_SLEEP, 1'b1, 4, "core_sleep_o after wfi_i");
  endtask

  task automatic leave_debug();
    dret_i = 1'b1;
    tick();
    dret_i = 1'b0;
    wait_for(SEL_RUN, 1'b1, 4, "debug_running_o after dret_i");
  endtask

  // One-cycle request
  task automatic request_debug();
    debug_req_i = 1'b1;
    tick();
    debug_req_i = 1'b0;
  endtask

  task automatic reset_and_boot();
    repeat (5) tick();
    fetch_enable_i = 1'b1;
    wait_for(SEL_RUN, 1'b1, 4, "debug_running_o after fetch_enable_i");
    finish_test("reset_and_boot");
  endtask

  task automatic irq_priority();
    logic [31:0] mask;
    m_irq_enable_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      seed = xorshift32(seed);
      // Odd rounds leave only the standard lines
      mask = (i % 2 == 1) ? (seed & 32'h0000_0888) : seed;
      seed = xorshift32(seed);
      take_irq(mask, seed);
    end
    // MSI wins over MTI despite its lower bit
    take_irq('1, 32'h0000_0088);
    // MEI wins over both
    take_irq('1, 32'h0000_0888);
    // Lowest fast line still beats MEI
    take_irq('1, 32'h0001_0800);
    // Reserved lines only
    clear_irqs();
    mie_i = '1;
    irq_i = ~IRQ_LINES;
    expect_no_ack(10);
    // Valid lines, global enable off
    m_irq_enable_i = 1'b0;
    clear_irqs();
    irq_i = IRQ_LINES;
    expect_no_ack(10);
    clear_irqs();
    finish_test("irq_priority");
  endtask

  task automatic sleep_wakeup();
    m_irq_enable_i = 1'b0;
    mie_i = 32'h0000_0080;
    enter_sleep();
    no_ack_exp = 1'b1;
    // MTI wakes even with the global enable off
    irq_i = 32'h0000_0080;
    wait_for(SEL_SLEEP, 1'b0, 6, "wake-up from a masked interrupt");
    wait_for(SEL_RUN, 1'b1, 2, "debug_running_o after wake-up");
    repeat (10) tick();
    clear_irqs();
    no_ack_exp = 1'b0;
    finish_test("sleep_wakeup");
  endtask

  task automatic debug_halt_return();
    request_debug();
    wait_for(SEL_HALT, 1'b1, SYNC_STAGES + 4, "debug_halted_o after debug_req_i");
    repeat (2) tick();
    leave_debug();
    finish_test("debug_halt_return");
  endtask

  task automatic debug_beats_irq();
    mie_i = '1;
    m_irq_enable_i = 1'b1;
    clear_irqs();
    no_ack_exp = 1'b1;
    exp_id = 5'd31;
    request_debug();
    // Irq reaches the FSM on the same edge as the synced request
    repeat (SYNC_STAGES - 1) tick();
    irq_i = 32'h8000_0000;
    wait_for(SEL_HALT, 1'b1, SYNC_STAGES + 4, "debug_halted_o with an irq pending");
    clear_irqs();
    leave_debug();
    no_ack_exp = 1'b0;
    finish_test("debug_beats_irq");
  endtask

  task automatic debug_wakes_sleep();
    enter_sleep();
    request_debug();
    wait_for(SEL_HALT, 1'b1, SYNC_STAGES + 4, "debug_halted_o from sleep");
    wait_for(SEL_SLEEP, 1'b0, 1, "core_sleep_o low in debug halt");
    leave_debug();
    finish_test("debug_wakes_sleep");
  endtask

`endif

/* tests/tb_core_ctrl.sv */
// Checks are concurrent assertions; debug_beats_irq lines its irq up with SYNC_STAGES
module tb_core_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SYNC_STAGES = 2;
  // Fast 31..16 plus MEI, MTI and MSI
  localparam logic [31:0] IRQ_LINES = 32'hFFFF_0888;
  // Selectors for wait_for
  localparam int SEL_ACK   = 0;
  localparam int SEL_SLEEP = 1;
  localparam int SEL_HALT  = 2;
  localparam int SEL_RUN   = 3;

  logic clk_i;
  logic rst_n_i;
  logic [31:0] irq_i;
  logic [31:0] mie_i;
  logic m_irq_enable_i;
  logic debug_req_i;
  logic fetch_enable_i;
  logic wfi_i;
  logic dret_i;
  logic irq_ack_o;
  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o;
  logic dbg_ack_o;
  logic core_sleep_o;
  logic debug_halted_o;
  logic debug_running_o;
  logic debug_havereset_o;
  // ack, dack, sleep, halt, run, havereset
  logic [5:0] status;

  int err_cnt;
  int test_errs;
  int tests_run;
  int tests_failed;
  logic [31:0] seed;
  logic [4:0] exp_id;
  // High while any irq ack would be wrong
  logic no_ack_exp;

  core_ctrl_top #(.DBG_SYNC_STAGES(SYNC_STAGES)) u_dut (.*);

  assign status = {irq_ack_o, dbg_ack_o, core_sleep_o,
                   debug_halted_o, debug_running_o, debug_havereset_o};

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset_status : assert property (@(posedge clk_i) !rst_n_i |=> status == 6'b00_0001)
    else log_error($sformatf(
        "[ERROR] status (ack,dack,sleep,halt,run,havereset): got 0x%02h expected 0x01",
        $sampled(status)));
  a_reset_id : assert property (@(posedge clk_i) !rst_n_i |=> irq_id_o == '0)
    else log_error($sformatf("[ERROR] irq_id_o after reset: got 0x%0h expected 0x0",
                             $sampled(irq_id_o)));
  // Core stays in BOOT_WAIT without fetch enable
  a_boot_wait : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (!fetch_enable_i && !debug_running_o && !debug_halted_o) |=> !debug_running_o)
    else log_error("Core started running with fetch_enable_i low");
  a_irq_id : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      irq_ack_o |-> irq_id_o == exp_id)
    else log_error($sformatf("[ERROR] irq_id_o: got 0x%0h expected 0x%0h",
                             $sampled(irq_id_o), exp_id));
  a_no_ack : assert property (@(posedge clk_i) disable iff (!rst_n_i) no_ack_exp |-> !irq_ack_o)
    else log_error("irq_ack_o pulsed while no interrupt may be taken");
  a_sleep_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(core_sleep_o) |-> $past(wfi_i))
    else log_error("core_sleep_o rose without a wfi_i pulse");
  // Sleeping still reports running
  a_sleep_running : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_sleep_o |-> debug_running_o)
    else log_error("debug_running_o low while core_sleep_o is high");
  a_halt_status : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      debug_halted_o |-> !debug_running_o && !core_sleep_o && !debug_havereset_o)
    else log_error("Halted with running, sleep or havereset still high");
  a_halt_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(debug_halted_o) |-> dbg_ack_o)
    else log_error("Debug halt entered without a dbg_ack_o pulse");
  a_halt_exit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(debug_halted_o) |-> $past(dret_i) && debug_running_o)
    else log_error("Debug halt left without dret_i or not back to running");

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic log_error(input string msg);
    err_cnt++;
    $display("%s (t=%0t)", msg, $time);
  endtask

  // Inputs change 2 ns after the edge, outputs read there too
  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_ACK:   return irq_ack_o;
      SEL_SLEEP: return core_sleep_o;
      SEL_HALT:  return debug_halted_o;
      default:   return debug_running_o;
    endcase
  endfunction

  task automatic wait_for(input int sel, input logic level, input int max_cyc, input string what);
    int n;
    n = 0;
    while (probe(sel) !== level && n < max_cyc) begin
      tick();
      n++;
    end
    if (probe(sel) !== level) begin
      log_error($sformatf("Timeout, no %s within %0d cycles", what, max_cyc));
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt != test_errs) begin
      tests_failed++;
      $display("[%0d] %s: failed with %0d error(s)", tests_run, name, err_cnt - test_errs);
    end else begin
      $display("[%0d] %s: ok", tests_run, name);
    end
    test_errs = err_cnt;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Winner: fast lines top down, then MEI, MSI, MTI
  function automatic logic [4:0] prio_id(input logic [31:0] v);
    logic [4:0] id;
    logic hit;
    id = 5'd0;
    hit = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (v[i] && !hit) begin
        id = 5'(i);
        hit = 1'b1;
      end
    end
    if (!hit) begin
      if (v[11]) begin
        id = 5'd11;
      end else if (v[3]) begin
        id = 5'd3;
      end else if (v[7]) begin
        id = 5'd7;
      end
    end
    return id;
  endfunction

  `include "core_ctrl_stim.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n_i = 1'b0;
    irq_i = '0;
    mie_i = '0;
    m_irq_enable_i = 1'b0;
    debug_req_i = 1'b0;
    fetch_enable_i = 1'b0;
    wfi_i = 1'b0;
    dret_i = 1'b0;
    err_cnt = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    seed = 32'h5142_c769;
    exp_id = '0;
    no_ack_exp = 1'b0;
    repeat (3) tick();
    rst_n_i = 1'b1;
    reset_and_boot();
    irq_priority();
    sleep_wakeup();
    debug_halt_return();
    debug_beats_irq();
    debug_wakes_sleep();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+tests
hdl/core_ctrl_pkg.sv
hdl/int_controller.sv
hdl/debug_req_unit.sv
hdl/core_ctrl_fsm.sv
hdl/core_ctrl_top.sv
tests/tb_core_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core control testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_core_ctrl \
  -Mdir obj_dir -o sim_core_ctrl

output="$(./obj_dir/sim_core_ctrl)"
echo "$output"

# Result is taken from the closing message of the testbench
if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
else
  exit 1
fi
